// ==== src/addr_calc.sv ====
`timescale 1ns/10ps

module addr_calc
    import lc3_isa_pkg::*;
    import exec_ctrl_pkg::*;
(
    input  logic       vif,
    input  logic       rst,
    input  logic       enable_execute,
    input  e_control_t e_control,
    input  word_t      IR,
    input  word_t      op_a,
    input  word_t      npc_in,
    output word_t      pcout
);

    offset_sel_t off_sel;
    word_t       offset;
    word_t       base;

    always_comb begin
        off_sel = offset_sel_t'(e_control[off_sel_msb:off_sel_lsb]);
        case (off_sel)
            off5:    offset = sign_ext(IR, imm5_w);
            off6:    offset = sign_ext(IR, off6_w);
            off9:    offset = sign_ext(IR, off9_w);   // BR, LD, LDI, LEA, ST, STI
            default: offset = sign_ext(IR, off11_w);
        endcase
    end

    // PC-relative or base-relative
    assign base = e_control[base_sel] ? npc_in : op_a;

    always_ff @(posedge vif) begin
        if (rst) begin
            pcout <= '0;
        end else if (enable_execute) begin
            pcout <= base + offset;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    a_pcout_reset : assert property (
        @(posedge vif) rst |=> (pcout == '0)
    ) else $error("addr_calc: pcout not cleared after reset");

endmodule

// ==== src/exec_alu.sv ====
`timescale 1ns/10ps

module exec_alu
    import lc3_isa_pkg::*;
    import exec_ctrl_pkg::*;
(
    input  logic       vif,
    input  logic       rst,
    input  logic       enable_execute,
    input  e_control_t e_control,
    input  word_t      IR,
    input  word_t      op_a,
    input  word_t      op_b,
    output word_t      aluout
);

    alu_op_t alu_op;
    word_t   src_b;
    word_t   result;

    //////////////////////////////////////////////////////////////////////
    // Operand B and ALU function
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_op = alu_op_t'(e_control[alu_op_msb:alu_op_lsb]);
        src_b  = e_control[use_imm] ? sign_ext(IR, imm5_w) : op_b;
    end

    always_comb begin
        case (alu_op)
            alu_add: result = op_a + src_b;
            alu_and: result = op_a & src_b;
            alu_not: result = ~op_a;
            default: result = '0;           // Unused code
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Result register, also the ALU forwarding source
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge vif) begin
        if (rst) begin
            aluout <= '0;
        end else if (enable_execute) begin
            aluout <= result;
        end
    end

    // Decode must never hand over the fourth ALU code
    a_alu_op_legal : assert property (
        @(posedge vif) disable iff (rst)
        enable_execute |-> (e_control[alu_op_msb:alu_op_lsb] != 2'd3)
    ) else $error("exec_alu: unused alu_op code with enable_execute high");

endmodule

// ==== src/exec_ctrl_pkg.sv ====
package exec_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // Execute control word from decode
    //////////////////////////////////////////////////////////////////////

    typedef logic [5:0] e_control_t;

    localparam int alu_op_msb  = 5;
    localparam int alu_op_lsb  = 4;
    localparam int off_sel_msb = 3;
    localparam int off_sel_lsb = 2;
    localparam int base_sel    = 1;   // 1 = npc_in, 0 = operand 1
    localparam int use_imm     = 0;   // 1 = imm5 replaces operand 2

    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_and = 2'd1,
        alu_not = 2'd2
    } alu_op_t;

    // Sign-extended IR offset used by the address adder
    typedef enum logic [1:0] {
        off5  = 2'd0,   // IR[4:0]
        off6  = 2'd1,   // IR[5:0]
        off9  = 2'd2,   // IR[8:0]
        off11 = 2'd3    // IR[10:0]
    } offset_sel_t;

    //////////////////////////////////////////////////////////////////////
    // Writeback control, passed through to later stages
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1,
        wb_pc  = 2'd2
    } w_control_t;

endpackage

// ==== src/exec_latch.sv ====
`timescale 1ns/10ps

module exec_latch
    import lc3_isa_pkg::*;
    import exec_ctrl_pkg::*;
(
    input  logic       vif,
    input  logic       rst,
    input  logic       enable_execute,
    input  word_t      IR,
    input  word_t      op_a,
    input  w_control_t W_Control_in,
    input  logic       Mem_Control_in,
    output w_control_t W_Control_out,
    output logic       Mem_Control_out,
    output word_t      M_Data,
    output reg_idx_t   dr,
    output reg_idx_t   NZP,
    output word_t      IR_Exec
);

    opcode_t opcode;
    logic    is_store;
    logic    is_load;
    logic    is_br;

    always_comb begin
        opcode   = opcode_t'(IR[op_msb:op_lsb]);
        is_store = opcode inside {op_st, op_str, op_sti};
        is_load  = opcode inside {op_ld, op_ldr, op_ldi};
        is_br    = (opcode == op_br);
    end

    //////////////////////////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge vif) begin
        if (rst) begin
            W_Control_out   <= wb_alu;
            Mem_Control_out <= 1'b0;
            M_Data          <= '0;
            dr              <= '0;
            NZP             <= '0;
            IR_Exec         <= '0;
        end else if (enable_execute) begin
            W_Control_out   <= W_Control_in;
            Mem_Control_out <= Mem_Control_in;
            M_Data          <= is_store ? op_a : '0;          // Store data from SR
            dr              <= IR[dr_msb:dr_lsb];
            NZP             <= is_br ? IR[dr_msb:dr_lsb] : '0; // n, z, p flags of BR
            IR_Exec         <= IR;
        end
    end

    // Depends on decode: the memory control bit is set for LDI and STI only
    a_mem_ctrl_idle : assert property (
        @(posedge vif) disable iff (rst)
        (enable_execute && !is_load && !is_store) |=> !Mem_Control_out
    ) else $error("exec_latch: Mem_Control_out set for a non-memory instruction");

endmodule

// ==== src/execute.sv ====
`timescale 1ns/10ps

module execute
    import lc3_isa_pkg::*;
    import exec_ctrl_pkg::*;
(
    input  logic       vif,
    input  logic       rst,
    input  logic       enable_execute,
    input  e_control_t E_Control_in,
    input  w_control_t W_Control_in,
    input  logic       Mem_Control_in,
    input  logic       bypass_alu_1,
    input  logic       bypass_alu_2,
    input  logic       bypass_mem_1,
    input  logic       bypass_mem_2,
    input  word_t      IR,
    input  word_t      npc_in,
    input  word_t      VSR1,
    input  word_t      VSR2,
    input  word_t      Mem_Bypass_val,
    output word_t      aluout,
    output word_t      pcout,
    output w_control_t W_Control_out,
    output logic       Mem_Control_out,
    output word_t      M_Data,
    output reg_idx_t   dr,
    output reg_idx_t   sr1,
    output reg_idx_t   sr2,
    output reg_idx_t   NZP,
    output word_t      IR_Exec
);

    word_t op_a;
    word_t op_b;

    // Register file read addresses, same cycle as IR
    assign sr1 = IR[sr1_msb:sr1_lsb];
    assign sr2 = IR[sr2_msb:sr2_lsb];

    //////////////////////////////////////////////////////////////////////
    // Operand selection
    //////////////////////////////////////////////////////////////////////

    operand_bypass u_bypass (
        .VSR1           (VSR1),
        .VSR2           (VSR2),
        .Mem_Bypass_val (Mem_Bypass_val),
        .alu_fwd        (aluout),          // Feedback of the stage's own result
        .bypass_alu_1   (bypass_alu_1),
        .bypass_alu_2   (bypass_alu_2),
        .bypass_mem_1   (bypass_mem_1),
        .bypass_mem_2   (bypass_mem_2),
        .op_a           (op_a),
        .op_b           (op_b)
    );

    //////////////////////////////////////////////////////////////////////
    // Datapath and stage register
    //////////////////////////////////////////////////////////////////////

    exec_alu u_alu (
        .vif            (vif),
        .rst            (rst),
        .enable_execute (enable_execute),
        .e_control      (E_Control_in),
        .IR             (IR),
        .op_a           (op_a),
        .op_b           (op_b),
        .aluout         (aluout)
    );

    addr_calc u_addr (
        .vif            (vif),
        .rst            (rst),
        .enable_execute (enable_execute),
        .e_control      (E_Control_in),
        .IR             (IR),
        .op_a           (op_a),
        .npc_in         (npc_in),
        .pcout          (pcout)
    );

    exec_latch u_latch (
        .vif             (vif),
        .rst             (rst),
        .enable_execute  (enable_execute),
        .IR              (IR),
        .op_a            (op_a),
        .W_Control_in    (W_Control_in),
        .Mem_Control_in  (Mem_Control_in),
        .W_Control_out   (W_Control_out),
        .Mem_Control_out (Mem_Control_out),
        .M_Data          (M_Data),
        .dr              (dr),
        .NZP             (NZP),
        .IR_Exec         (IR_Exec)
    );

endmodule

// ==== src/lc3_isa_pkg.sv ====
package lc3_isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // Data and instruction words
    //////////////////////////////////////////////////////////////////////

    localparam int word_w = 16;

    typedef logic [word_w-1:0] word_t;
    typedef logic [2:0]        reg_idx_t;  // Register number or NZP bits

    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_ld  = 4'b0010,
        op_st  = 4'b0011,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001,
        op_ldi = 4'b1010,
        op_sti = 4'b1011,
        op_jmp = 4'b1100,
        op_lea = 4'b1110
    } opcode_t;

    //////////////////////////////////////////////////////////////////////
    // Instruction fields
    //////////////////////////////////////////////////////////////////////

    localparam int op_msb       = 15;
    localparam int op_lsb       = 12;
    localparam int dr_msb       = 11;
    localparam int dr_lsb       = 9;
    localparam int sr1_msb      = 8;
    localparam int sr1_lsb      = 6;
    localparam int sr2_msb      = 2;
    localparam int sr2_lsb      = 0;
    localparam int imm_flag_bit = 5;   // Register or immediate form of ADD/AND

    // Offset widths, all fields start at bit 0
    localparam int imm5_w  = 5;
    localparam int off6_w  = 6;
    localparam int off9_w  = 9;
    localparam int off11_w = 11;

    // Sign-extends the low width bits of raw to a full word
    function automatic word_t sign_ext(input word_t raw, input int unsigned width);
        word_t mask;
        mask = '1 << width;
        return raw[width-1] ? (raw | mask) : (raw & ~mask);
    endfunction

endpackage

// ==== src/operand_bypass.sv ====
`timescale 1ns/10ps

module operand_bypass
    import lc3_isa_pkg::*;
(
    input  word_t VSR1,
    input  word_t VSR2,
    input  word_t Mem_Bypass_val,
    input  word_t alu_fwd,          // Last enabled ALU result
    input  logic  bypass_alu_1,
    input  logic  bypass_alu_2,
    input  logic  bypass_mem_1,
    input  logic  bypass_mem_2,
    output word_t op_a,
    output word_t op_b
);

    // ALU result is newer than the memory value, so it takes priority
    function automatic word_t pick(
        input word_t reg_val,
        input word_t mem_val,
        input word_t alu_val,
        input logic  use_alu,
        input logic  use_mem
    );
        word_t sel;
        if (use_alu) begin
            sel = alu_val;
        end else if (use_mem) begin
            sel = mem_val;
        end else begin
            sel = reg_val;
        end
        return sel;
    endfunction

    always_comb begin
        op_a = pick(VSR1, Mem_Bypass_val, alu_fwd, bypass_alu_1, bypass_mem_1);
        op_b = pick(VSR2, Mem_Bypass_val, alu_fwd, bypass_alu_2, bypass_mem_2);
    end

endmodule

// ==== testbench/execute_tb.sv ====
`timescale 1ns/10ps

module execute_tb
    import lc3_isa_pkg::*;
    import exec_ctrl_pkg::*;
;

    localparam int run_cycles    = 2000;
    localparam int run_timeout   = 3000;
    localparam int reset_timeout = 10;

    logic       vif = 1'b0;
    logic       rst;
    logic       enable_execute;
    e_control_t E_Control_in;
    w_control_t W_Control_in;
    logic       Mem_Control_in;
    logic       bypass_alu_1;
    logic       bypass_alu_2;
    logic       bypass_mem_1;
    logic       bypass_mem_2;
    word_t      IR;
    word_t      npc_in;
    word_t      VSR1;
    word_t      VSR2;
    word_t      Mem_Bypass_val;

    word_t      aluout;
    word_t      pcout;
    w_control_t W_Control_out;
    logic       Mem_Control_out;
    word_t      M_Data;
    reg_idx_t   dr;
    reg_idx_t   sr1;
    reg_idx_t   sr2;
    reg_idx_t   NZP;
    word_t      IR_Exec;

    // Expected values of the stage register
    word_t      exp_aluout;
    word_t      exp_pcout;
    w_control_t exp_wctrl;
    logic       exp_memctrl;
    word_t      exp_mdata;
    reg_idx_t   exp_dr;
    reg_idx_t   exp_nzp;
    word_t      exp_ir;

    logic        model_on  = 1'b0;    // Set by the first reset edge
    logic        hold_prev = 1'b0;    // Last edge was a stall
    logic [72:0] all_out;
    logic [72:0] prev_out;
    logic        stim_on   = 1'b0;
    int          cycle_count = 0;
    int          error_count = 0;

    opcode_t opcode_list [12] = '{op_add, op_and, op_not, op_br, op_jmp, op_ld,
                                  op_ldr, op_ldi, op_lea, op_st, op_str, op_sti};

    assign all_out = {aluout, pcout, W_Control_out, Mem_Control_out, M_Data, dr, NZP, IR_Exec};

    always #4 vif = ~vif;

    execute u_execute (
        .vif             (vif),
        .rst             (rst),
        .enable_execute  (enable_execute),
        .E_Control_in    (E_Control_in),
        .W_Control_in    (W_Control_in),
        .Mem_Control_in  (Mem_Control_in),
        .bypass_alu_1    (bypass_alu_1),
        .bypass_alu_2    (bypass_alu_2),
        .bypass_mem_1    (bypass_mem_1),
        .bypass_mem_2    (bypass_mem_2),
        .IR              (IR),
        .npc_in          (npc_in),
        .VSR1            (VSR1),
        .VSR2            (VSR2),
        .Mem_Bypass_val  (Mem_Bypass_val),
        .aluout          (aluout),
        .pcout           (pcout),
        .W_Control_out   (W_Control_out),
        .Mem_Control_out (Mem_Control_out),
        .M_Data          (M_Data),
        .dr              (dr),
        .sr1             (sr1),
        .sr2             (sr2),
        .NZP             (NZP),
        .IR_Exec         (IR_Exec)
    );

    task automatic report_mismatch(input string name, input logic [79:0] expected,
                                   input logic [79:0] actual);
        error_count++;
        $display("mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual);
        $display("TB FAILED");
        $fatal(1, "check %s failed at %0t", name, $time);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Control words as the decode stage would hand them over
    task automatic decode_controls(input opcode_t op, input logic imm_flag,
                                   output e_control_t ec, output w_control_t wc,
                                   output logic mc);
        case (op)
            op_add:  ec = {alu_add, off5, 1'b0, imm_flag};
            op_and:  ec = {alu_and, off5, 1'b0, imm_flag};
            op_not:  ec = {alu_not, off5, 1'b0, 1'b0};
            op_jmp:  ec = {alu_add, off6, 1'b0, 1'b0};
            op_ldr:  ec = {alu_add, off6, 1'b0, 1'b0};
            op_str:  ec = {alu_add, off6, 1'b0, 1'b0};
            default: ec = {alu_add, off9, 1'b1, 1'b0};   // PC-relative forms
        endcase
        case (op)
            op_add, op_and, op_not: wc = wb_alu;
            op_ld, op_ldr, op_ldi:  wc = wb_mem;
            op_lea:                 wc = wb_pc;
            default:                wc = wb_alu;
        endcase
        mc = (op == op_ldi) || (op == op_sti);
    endtask

    // Returns {alu flag, mem flag} with both set now and then
    function automatic logic [1:0] bypass_pair();
        int unsigned pick;
        pick = $urandom_range(0, 7);
        if (pick == 7) begin
            return 2'b11;
        end else if (pick >= 5) begin
            return 2'b10;
        end else if (pick == 4) begin
            return 2'b01;
        end
        return 2'b00;
    endfunction

    task automatic drive_random_cycle();
        opcode_t    op;
        word_t      ir_v;
        e_control_t ec;
        w_control_t wc;
        logic       mc;
        logic [1:0] fwd_1;
        logic [1:0] fwd_2;
        op    = opcode_list[$urandom_range(0, 11)];
        ir_v  = {op, 12'($urandom)};
        fwd_1 = bypass_pair();
        fwd_2 = bypass_pair();
        decode_controls(op, ir_v[imm_flag_bit], ec, wc, mc);
        rst            <= ($urandom_range(0, 63) == 0);
        enable_execute <= ($urandom_range(0, 3) != 0);
        IR             <= ir_v;
        E_Control_in   <= ec;
        W_Control_in   <= wc;
        Mem_Control_in <= mc;
        {bypass_alu_1, bypass_mem_1} <= fwd_1;
        {bypass_alu_2, bypass_mem_2} <= fwd_2;
        npc_in         <= 16'($urandom);
        VSR1           <= 16'($urandom);
        VSR2           <= 16'($urandom);
        Mem_Bypass_val <= 16'($urandom);
    endtask

    always @(posedge vif) begin
        if (stim_on) begin
            drive_random_cycle();
            cycle_count <= cycle_count + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    always @(posedge vif) begin : ref_model
        word_t a;
        word_t b;
        word_t b_alu;
        word_t off;
        if (rst) begin
            exp_aluout  <= '0;
            exp_pcout   <= '0;
            exp_wctrl   <= wb_alu;
            exp_memctrl <= 1'b0;
            exp_mdata   <= '0;
            exp_dr      <= '0;
            exp_nzp     <= '0;
            exp_ir      <= '0;
            model_on    <= 1'b1;
        end else if (enable_execute) begin
            a = bypass_alu_1 ? exp_aluout : (bypass_mem_1 ? Mem_Bypass_val : VSR1);
            b = bypass_alu_2 ? exp_aluout : (bypass_mem_2 ? Mem_Bypass_val : VSR2);
            b_alu = E_Control_in[use_imm] ? {{11{IR[4]}}, IR[4:0]} : b;
            case (E_Control_in[alu_op_msb:alu_op_lsb])
                2'd0:    exp_aluout <= a + b_alu;
                2'd1:    exp_aluout <= a & b_alu;
                2'd2:    exp_aluout <= ~a;
                default: exp_aluout <= '0;
            endcase
            case (E_Control_in[off_sel_msb:off_sel_lsb])
                2'd0:    off = {{11{IR[4]}}, IR[4:0]};
                2'd1:    off = {{10{IR[5]}}, IR[5:0]};
                2'd2:    off = {{7{IR[8]}}, IR[8:0]};
                default: off = {{5{IR[10]}}, IR[10:0]};
            endcase
            exp_pcout   <= (E_Control_in[base_sel] ? npc_in : a) + off;
            exp_wctrl   <= W_Control_in;
            exp_memctrl <= Mem_Control_in;
            exp_mdata   <= (IR[15:12] inside {op_st, op_str, op_sti}) ? a : '0;
            exp_dr      <= IR[11:9];
            exp_nzp     <= (IR[15:12] == op_br) ? IR[11:9] : '0;
            exp_ir      <= IR;
        end
        hold_prev <= model_on && !rst && !enable_execute;
        prev_out  <= all_out;
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    chk_aluout : assert property (@(posedge vif) model_on |-> aluout == exp_aluout)
        else report_mismatch("aluout", $sampled(exp_aluout), $sampled(aluout));
    chk_pcout : assert property (@(posedge vif) model_on |-> pcout == exp_pcout)
        else report_mismatch("pcout", $sampled(exp_pcout), $sampled(pcout));
    chk_wctrl : assert property (@(posedge vif) model_on |-> W_Control_out == exp_wctrl)
        else report_mismatch("W_Control_out", $sampled(exp_wctrl), $sampled(W_Control_out));
    chk_memctrl : assert property (@(posedge vif) model_on |-> Mem_Control_out == exp_memctrl)
        else report_mismatch("Mem_Control_out", $sampled(exp_memctrl),
                             $sampled(Mem_Control_out));
    chk_mdata : assert property (@(posedge vif) model_on |-> M_Data == exp_mdata)
        else report_mismatch("M_Data", $sampled(exp_mdata), $sampled(M_Data));
    chk_dr : assert property (@(posedge vif) model_on |-> dr == exp_dr)
        else report_mismatch("dr", $sampled(exp_dr), $sampled(dr));
    chk_nzp : assert property (@(posedge vif) model_on |-> NZP == exp_nzp)
        else report_mismatch("NZP", $sampled(exp_nzp), $sampled(NZP));
    chk_ir_exec : assert property (@(posedge vif) model_on |-> IR_Exec == exp_ir)
        else report_mismatch("IR_Exec", $sampled(exp_ir), $sampled(IR_Exec));

    chk_sr1 : assert property (@(posedge vif) sr1 == IR[8:6])
        else report_mismatch("sr1", $sampled(IR[8:6]), $sampled(sr1));
    chk_sr2 : assert property (@(posedge vif) sr2 == IR[2:0])
        else report_mismatch("sr2", $sampled(IR[2:0]), $sampled(sr2));

    // All registered outputs as one vector
    chk_reset_clear : assert property (@(posedge vif) rst |=> all_out == '0)
        else report_mismatch("reset_clear", 80'd0, $sampled(all_out));
    chk_stall_hold : assert property (@(posedge vif) hold_prev |-> all_out == prev_out)
        else report_mismatch("stall_hold", $sampled(prev_out), $sampled(all_out));

    //////////////////////////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////////////////////////

    task automatic init_inputs();
        enable_execute = 1'b0;
        E_Control_in   = '0;
        W_Control_in   = wb_alu;
        Mem_Control_in = 1'b0;
        bypass_alu_1   = 1'b0;
        bypass_alu_2   = 1'b0;
        bypass_mem_1   = 1'b0;
        bypass_mem_2   = 1'b0;
        IR             = '0;
        npc_in         = '0;
        VSR1           = '0;
        VSR2           = '0;
        Mem_Bypass_val = '0;
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst !== 1'b0 && waited < reset_timeout) begin
            @(posedge vif);
            waited++;
        end
        if (rst !== 1'b0) begin
            $display("Reset was not released within %0d cycles", reset_timeout);
            $display("TB FAILED");
            $fatal(1, "reset timeout");
        end
    endtask

    task automatic wait_run_done();
        int waited;
        waited = 0;
        while (cycle_count < run_cycles && waited < run_timeout) begin
            @(posedge vif);
            waited++;
        end
        if (cycle_count < run_cycles) begin
            $display("Stimulus stopped after %0d of %0d cycles", cycle_count, run_cycles);
            $display("TB FAILED");
            $fatal(1, "run timeout");
        end
    endtask

    initial begin
        void'($urandom(57800));
        init_inputs();
        rst = 1'b1;
        repeat (2) @(posedge vif);    // Reset held for two cycles
        rst <= 1'b0;
        wait_reset_release();
        stim_on <= 1'b1;
        wait_run_done();
        @(posedge vif);               // Let the last checks fire
        if (error_count != 0) begin
            $display("TB FAILED");
            $fatal(1, "%0d checks failed", error_count);
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
src/lc3_isa_pkg.sv
src/exec_ctrl_pkg.sv
src/operand_bypass.sv
src/exec_alu.sv
src/addr_calc.sv
src/exec_latch.sv
src/execute.sv
testbench/execute_tb.sv
